//--- hdl/rt_pkg.sv
/*
  Ray/triangle unit shared types.
  Signed Q16.16 fixed point, vectors, rays, affine triangles and
  intersection records, plus the pipeline stage counts.
*/
`default_nettype none

package rt_pkg;

  localparam int FRAC = 16;

  typedef logic signed [31:0] fix_t;
  typedef logic signed [63:0] wide_t;

  // 1.0 in Q16.16
  localparam fix_t ONE_FIX = 32'sh0001_0000;

  typedef struct packed {
    fix_t x;
    fix_t y;
    fix_t z;
  } vector_t;

  typedef struct packed {
    vector_t     origin;
    vector_t     dir;
    fix_t        t_max;
    logic [7:0]  ray_id;
  } ray_t;

  // one affine row, a*px + b*py + c*pz + d
  typedef struct packed {
    fix_t a;
    fix_t b;
    fix_t c;
    fix_t d;
  } row_t;

  typedef struct packed {
    row_t        r0;
    row_t        r1;
    row_t        r2;
    logic [15:0] tri_id;
  } tri_t;

  typedef enum logic {
    LANE0 = 1'b0,
    LANE1 = 1'b1
  } lane_sel_e;

  typedef struct packed {
    logic [15:0] tri_id;
    fix_t        t;
    vector_t     p_int;
    fix_t        u;
    fix_t        v;
  } isect_t;

  localparam int PC_LAT   = 2;
  localparam int DIV_LAT  = 32;
  localparam int UV_LAT   = 2;
  localparam int TC_LAT   = 2;
  localparam int LANE_LAT = PC_LAT + DIV_LAT + UV_LAT;
  localparam int UNIT_LAT = LANE_LAT + TC_LAT;

  // full product scaled back by FRAC, arithmetic shift
  function automatic wide_t mul_q(input fix_t a, input fix_t b);
    wide_t prod;
    prod = wide_t'(a) * wide_t'(b);
    return prod >>> FRAC;
  endfunction

endpackage

`default_nettype wire

//--- hdl/lane_result_if.sv
/*
  Lane result bundle.
  One lane's hit distance, barycentric coordinates and hit flag,
  passed from a tuv_calc lane to the combiner.
*/
`default_nettype none

interface lane_result_if;
  import rt_pkg::*;

  fix_t t;
  fix_t u;
  fix_t v;
  logic hit;

  modport lane (
    output t, u, v, hit
  );

  modport comb (
    input t, u, v, hit
  );

endinterface

`default_nettype wire

//--- hdl/delay_line.sv
/*
  Fixed-latency delay line.
  Shifts a WIDTH-bit bus through LAT registers so side data
  lines up with the arithmetic lanes. Cleared on reset.
*/
`default_nettype none

module delay_line #(
  parameter int LAT   = 1,
  parameter int WIDTH = 1
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [WIDTH-1:0] d,
  output logic [WIDTH-1:0] q
);

  logic [WIDTH-1:0] pipe [LAT];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < LAT; i++) begin
        pipe[i] <= '0;
      end
    end else begin
      pipe[0] <= d;
      for (int i = 1; i < LAT; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  assign q = pipe[LAT-1];

endmodule

`default_nettype wire

//--- hdl/prime_calc.sv
/*
  Ray transform into triangle unit space.
  Stage 1 forms the nine origin and nine direction products,
  stage 2 sums each affine row. The origin gets the row offset d,
  the direction does not.
*/
`default_nettype none

module prime_calc (
  input  logic            clk,
  input  logic            arst_n,
  input  rt_pkg::ray_t    ray_in,
  input  rt_pkg::tri_t    tri_in,
  output rt_pkg::vector_t org_p,
  output rt_pkg::vector_t dir_p
);
  import rt_pkg::*;

  function automatic fix_t row_coef(input row_t row, input int col);
    fix_t c;
    case (col)
      0:       c = row.a;
      1:       c = row.b;
      default: c = row.c;
    endcase
    return c;
  endfunction

  row_t  rows  [3];
  fix_t  org_v [3];
  fix_t  dir_v [3];

  // stage 1 products, indexed [row][column]
  wide_t o_prod [3][3];
  wide_t d_prod [3][3];
  fix_t  d_q    [3];

  fix_t  org_w  [3];
  fix_t  dir_w  [3];

  assign rows[0] = tri_in.r0;
  assign rows[1] = tri_in.r1;
  assign rows[2] = tri_in.r2;

  assign org_v[0] = ray_in.origin.x;
  assign org_v[1] = ray_in.origin.y;
  assign org_v[2] = ray_in.origin.z;
  assign dir_v[0] = ray_in.dir.x;
  assign dir_v[1] = ray_in.dir.y;
  assign dir_v[2] = ray_in.dir.z;

  always_ff @(posedge clk) begin
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        o_prod[r][c] <= mul_q(row_coef(rows[r], c), org_v[c]);
        d_prod[r][c] <= mul_q(row_coef(rows[r], c), dir_v[c]);
      end
      d_q[r] <= rows[r].d;
    end
  end

  // row sums, truncated back to Q16.16
  always_comb begin
    for (int r = 0; r < 3; r++) begin
      org_w[r] = fix_t'(o_prod[r][0] + o_prod[r][1] + o_prod[r][2] + wide_t'(d_q[r]));
      dir_w[r] = fix_t'(d_prod[r][0] + d_prod[r][1] + d_prod[r][2]);
    end
  end

  // stage 2, transformed origin and direction
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      org_p <= '0;
      dir_p <= '0;
    end else begin
      org_p <= '{x: org_w[0], y: org_w[1], z: org_w[2]};
      dir_p <= '{x: dir_w[0], y: dir_w[1], z: dir_w[2]};
    end
  end

endmodule

`default_nettype wire

//--- hdl/tuv_calc.sv
/*
  Hit distance and barycentric stage of one lane.
  A restoring divider yields t = -oz/dz one quotient bit per stage,
  then u, v are evaluated and the inside-triangle test sets hit.
*/
`default_nettype none

module tuv_calc (
  input  logic            clk,
  input  logic            arst_n,
  input  rt_pkg::vector_t org_p,
  input  rt_pkg::vector_t dir_p,
  lane_result_if.lane     res
);
  import rt_pkg::*;

  typedef struct packed {
    logic [31:0] rem;
    logic [31:0] quo;
    logic [31:0] den;
    logic [31:0] num;
    fix_t        ox;
    fix_t        oy;
    fix_t        dx;
    fix_t        dy;
    logic        neg;
    logic        ovf;
  } div_stage_t;

  // one restoring step, brings in the next numerator bit
  function automatic div_stage_t div_step(input div_stage_t s);
    div_stage_t  r;
    logic [32:0] trial;
    r     = s;
    trial = {s.rem, s.num[31]};
    r.num = {s.num[30:0], 1'b0};
    if (trial >= {1'b0, s.den}) begin
      r.rem = 32'(trial - {1'b0, s.den});
      r.quo = {s.quo[30:0], 1'b1};
    end else begin
      r.rem = trial[31:0];
      r.quo = {s.quo[30:0], 1'b0};
    end
    return r;
  endfunction

  logic [31:0]        abs_oz;
  logic [31:0]        abs_dz;
  div_stage_t         div_in;
  div_stage_t         div_q [DIV_LAT];
  div_stage_t         div_o;
  logic [DIV_LAT-1:0] nz_q;

  logic [31:0]        t_mag;
  fix_t               t_val;
  fix_t               t1, u1, v1;
  logic               nz1;
  logic signed [32:0] uv_sum;
  fix_t               t2, u2, v2;
  logic               hit2;

  // numerator is |oz| << FRAC; its top 16 bits seed the remainder
  always_comb begin
    abs_oz     = org_p.z[31] ? -org_p.z : org_p.z;
    abs_dz     = dir_p.z[31] ? -dir_p.z : dir_p.z;
    div_in.rem = {16'b0, abs_oz[31:16]};
    div_in.quo = '0;
    div_in.den = abs_dz;
    div_in.num = {abs_oz[15:0], 16'b0};
    div_in.ox  = org_p.x;
    div_in.oy  = org_p.y;
    div_in.dx  = dir_p.x;
    div_in.dy  = dir_p.y;
    div_in.neg = (org_p.z[31] == dir_p.z[31]);
    // quotient would not fit in 32 bits, also true for dz == 0
    div_in.ovf = ({16'b0, abs_oz[31:16]} >= abs_dz);
  end

  always_ff @(posedge clk) begin
    div_q[0] <= div_step(div_in);
    for (int k = 1; k < DIV_LAT; k++) begin
      div_q[k] <= div_step(div_q[k-1]);
    end
  end

  // nonzero dz flag rides alongside the divider
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      nz_q <= '0;
    end else begin
      nz_q <= {nz_q[DIV_LAT-2:0], (dir_p.z != '0)};
    end
  end

  // saturate on overflow, then apply the sign
  assign div_o = div_q[DIV_LAT-1];
  assign t_mag = (div_o.ovf || div_o.quo[31]) ? 32'h7fff_ffff : div_o.quo;
  assign t_val = div_o.neg ? -fix_t'(t_mag) : fix_t'(t_mag);

  always_ff @(posedge clk) begin
    t1 <= t_val;
    u1 <= div_o.ox + fix_t'(mul_q(t_val, div_o.dx));
    v1 <= div_o.oy + fix_t'(mul_q(t_val, div_o.dy));
    t2 <= t1;
    u2 <= u1;
    v2 <= v1;
  end

  assign uv_sum = {u1[31], u1} + {v1[31], v1};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      nz1  <= 1'b0;
      hit2 <= 1'b0;
    end else begin
      nz1  <= nz_q[DIV_LAT-1];
      hit2 <= nz1 && (t1 > 0) && (u1 >= 0) && (v1 >= 0) && (uv_sum <= ONE_FIX);
    end
  end

  assign res.t   = t2;
  assign res.u   = u2;
  assign res.v   = v2;
  assign res.hit = hit2;

endmodule

`default_nettype wire

//--- hdl/t_comp.sv
/*
  Lane combiner.
  Qualifies both lane hits against t_max, keeps the nearer one
  (lane 0 on ties), pulses miss after stage 1 or emits the hit
  record with its hit point after stage 2.
*/
`default_nettype none

module t_comp (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            vld,
  input  rt_pkg::ray_t    ray_in,
  input  logic [15:0]     tri0_id,
  input  logic [15:0]     tri1_id,
  lane_result_if.comb     lane0,
  lane_result_if.comb     lane1,
  output logic            miss_valid,
  output rt_pkg::ray_t    miss_ray,
  output logic            hit_valid,
  output rt_pkg::ray_t    hit_ray,
  output rt_pkg::isect_t  hit_isect
);
  import rt_pkg::*;

  logic        q0;
  logic        q1;
  lane_sel_e   sel;

  logic        s1_hit;
  lane_sel_e   s1_sel;
  ray_t        s1_ray;
  fix_t        s1_t  [2];
  fix_t        s1_u  [2];
  fix_t        s1_v  [2];
  logic [15:0] s1_id [2];

  fix_t        t_w;
  vector_t     p_w;

  assign q0 = lane0.hit && (lane0.t <= ray_in.t_max);
  assign q1 = lane1.hit && (lane1.t <= ray_in.t_max);

  always_comb begin
    if (q1 && (!q0 || (lane1.t < lane0.t))) begin
      sel = LANE1;
    end else begin
      sel = LANE0;
    end
  end

  // stage 1
  always_ff @(posedge clk) begin
    s1_sel   <= sel;
    s1_ray   <= ray_in;
    s1_t[0]  <= lane0.t;
    s1_t[1]  <= lane1.t;
    s1_u[0]  <= lane0.u;
    s1_u[1]  <= lane1.u;
    s1_v[0]  <= lane0.v;
    s1_v[1]  <= lane1.v;
    s1_id[0] <= tri0_id;
    s1_id[1] <= tri1_id;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_hit     <= 1'b0;
      miss_valid <= 1'b0;
    end else begin
      s1_hit     <= vld && (q0 || q1);
      miss_valid <= vld && !(q0 || q1);
    end
  end

  assign miss_ray = s1_ray;

  // hit point p = origin + t*dir
  assign t_w     = s1_t[s1_sel];
  assign p_w.x   = s1_ray.origin.x + fix_t'(mul_q(t_w, s1_ray.dir.x));
  assign p_w.y   = s1_ray.origin.y + fix_t'(mul_q(t_w, s1_ray.dir.y));
  assign p_w.z   = s1_ray.origin.z + fix_t'(mul_q(t_w, s1_ray.dir.z));

  // stage 2
  always_ff @(posedge clk) begin
    hit_ray          <= s1_ray;
    hit_isect.tri_id <= s1_id[s1_sel];
    hit_isect.t      <= t_w;
    hit_isect.p_int  <= p_w;
    hit_isect.u      <= s1_u[s1_sel];
    hit_isect.v      <= s1_v[s1_sel];
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hit_valid <= 1'b0;
    end else begin
      hit_valid <= s1_hit;
    end
  end

endmodule

`default_nettype wire

//--- hdl/ray_tri_unit.sv
/*
  Ray/triangle intersection unit, top level.
  Two lanes test one ray against two triangles side by side;
  the ray, triangle ids and valid are delayed to meet the lane
  results at the combiner. One miss or hit pulse per valid_in.
*/
`default_nettype none

module ray_tri_unit (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           valid_in,
  input  rt_pkg::ray_t   ray_in,
  input  rt_pkg::tri_t   tri0_in,
  input  rt_pkg::tri_t   tri1_in,
  output logic           miss_valid,
  output rt_pkg::ray_t   miss_ray,
  output logic           hit_valid,
  output rt_pkg::ray_t   hit_ray,
  output rt_pkg::isect_t hit_isect
);
  import rt_pkg::*;

  localparam int SIDE_W = $bits(ray_t) + 32;

  vector_t           org0, dir0;
  vector_t           org1, dir1;
  logic [SIDE_W-1:0] side_d;
  logic [SIDE_W-1:0] side_q;
  ray_t              ray_d;
  logic [15:0]       id0_d;
  logic [15:0]       id1_d;
  logic              vld_d;

  lane_result_if lr0 ();
  lane_result_if lr1 ();

  // lane 0
  prime_calc pc0 (.clk, .arst_n, .ray_in, .tri_in(tri0_in), .org_p(org0), .dir_p(dir0));
  tuv_calc tuv0 (.clk, .arst_n, .org_p(org0), .dir_p(dir0), .res(lr0.lane));

  // lane 1
  prime_calc pc1 (.clk, .arst_n, .ray_in, .tri_in(tri1_in), .org_p(org1), .dir_p(dir1));
  tuv_calc tuv1 (.clk, .arst_n, .org_p(org1), .dir_p(dir1), .res(lr1.lane));

  // ray and ids ride next to the lanes
  assign side_d = {ray_in, tri0_in.tri_id, tri1_in.tri_id};
  assign {ray_d, id0_d, id1_d} = side_q;

  delay_line #(.LAT(LANE_LAT), .WIDTH(SIDE_W)) ray_dly (
    .clk,
    .arst_n,
    .d(side_d),
    .q(side_q)
  );

  delay_line #(.LAT(LANE_LAT), .WIDTH(1)) vld_dly (
    .clk,
    .arst_n,
    .d(valid_in),
    .q(vld_d)
  );

  t_comp tc (
    .clk,
    .arst_n,
    .vld(vld_d),
    .ray_in(ray_d),
    .tri0_id(id0_d),
    .tri1_id(id1_d),
    .lane0(lr0.comb),
    .lane1(lr1.comb),
    .miss_valid,
    .miss_ray,
    .hit_valid,
    .hit_ray,
    .hit_isect
  );

endmodule

`default_nettype wire

//--- bench/ray_tri_model.svh
/*
  Reference model for the ray/triangle unit.
  Q16.16 transform, divide, barycentric test and nearest-hit
  choice in 64-bit integers, plus the stimulus LCG.
*/
`ifndef RAY_TRI_MODEL_SVH
`define RAY_TRI_MODEL_SVH

typedef struct {
  logic   is_hit;
  ray_t   ray;
  isect_t isect;
  int     issue;
} exp_t;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// full product, scaled back with an arithmetic shift
function automatic longint qmul(input fix_t a, input fix_t b);
  longint p;
  p = longint'(a) * longint'(b);
  return p >>> FRAC;
endfunction

function automatic fix_t row_apply(input row_t r, input vector_t p, input bit with_d);
  longint s;
  s = qmul(r.a, p.x) + qmul(r.b, p.y) + qmul(r.c, p.z);
  if (with_d) begin
    s = s + longint'(r.d);
  end
  return fix_t'(s);
endfunction

function automatic void lane_ref(input ray_t ray, input tri_t tr, output logic hit,
                                 output fix_t t, output fix_t u, output fix_t v);
  vector_t o;
  vector_t d;
  longint  num;
  longint  den;
  longint  q;
  o.x = row_apply(tr.r0, ray.origin, 1'b1);
  o.y = row_apply(tr.r1, ray.origin, 1'b1);
  o.z = row_apply(tr.r2, ray.origin, 1'b1);
  d.x = row_apply(tr.r0, ray.dir, 1'b0);
  d.y = row_apply(tr.r1, ray.dir, 1'b0);
  d.z = row_apply(tr.r2, ray.dir, 1'b0);
  // t = -oz/dz on magnitudes, clamped to the largest fix_t
  num = (o.z < 0) ? -longint'(o.z) : longint'(o.z);
  num = num <<< FRAC;
  den = (d.z < 0) ? -longint'(d.z) : longint'(d.z);
  q = 64'sh7fff_ffff;
  if (den != 0) begin
    if (num / den <= 64'sh7fff_ffff) begin
      q = num / den;
    end
  end
  t = ((o.z < 0) == (d.z < 0)) ? -fix_t'(q) : fix_t'(q);
  u = fix_t'(longint'(o.x) + qmul(t, d.x));
  v = fix_t'(longint'(o.y) + qmul(t, d.y));
  hit = (d.z != 0) && (t > 0) && (u >= 0) && (v >= 0) &&
        (longint'(u) + longint'(v) <= 64'sd65536);
endfunction

function automatic exp_t expect_item(input ray_t ray, input tri_t tr0, input tri_t tr1);
  exp_t e;
  logic h0, h1, q0, q1, pick1;
  fix_t t0, u0, v0, t1, u1, v1, tw;
  lane_ref(ray, tr0, h0, t0, u0, v0);
  lane_ref(ray, tr1, h1, t1, u1, v1);
  q0 = h0 && (t0 <= ray.t_max);
  q1 = h1 && (t1 <= ray.t_max);
  // lane 0 keeps ties
  pick1 = q1 && (!q0 || (t1 < t0));
  tw = pick1 ? t1 : t0;
  e.is_hit = q0 || q1;
  e.ray = ray;
  e.issue = 0;
  e.isect.tri_id = pick1 ? tr1.tri_id : tr0.tri_id;
  e.isect.t = tw;
  e.isect.u = pick1 ? u1 : u0;
  e.isect.v = pick1 ? v1 : v0;
  e.isect.p_int.x = fix_t'(longint'(ray.origin.x) + qmul(tw, ray.dir.x));
  e.isect.p_int.y = fix_t'(longint'(ray.origin.y) + qmul(tw, ray.dir.y));
  e.isect.p_int.z = fix_t'(longint'(ray.origin.z) + qmul(tw, ray.dir.z));
  return e;
endfunction

`endif

//--- bench/tb_ray_tri_unit.sv
/*
  Testbench for the ray/triangle intersection unit.
  Directed lane, tie, t_max and miss cases, then random items
  back to back, each result checked against the fixed-point model.
*/
`default_nettype none

module tb_ray_tri_unit;
  import rt_pkg::*;

  `include "ray_tri_model.svh"

  localparam fix_t F_ONE       = 32'sh0001_0000;
  localparam int   DRAIN_LIMIT = 200;
  localparam int   N_RANDOM    = 300;

  logic   clk;
  logic   arst_n;
  logic   valid_in;
  ray_t   ray_in;
  tri_t   tri0_in;
  tri_t   tri1_in;
  logic   miss_valid;
  ray_t   miss_ray;
  logic   hit_valid;
  ray_t   hit_ray;
  isect_t hit_isect;

  exp_t        exp_q [$];
  int          outstanding = 0;
  int          errors = 0;
  int          items = 0;
  int          cyc = 0;
  logic [31:0] rng = 32'h3a75deba;

  ray_tri_unit dut0 (
    .clk(clk),
    .arst_n(arst_n),
    .valid_in(valid_in),
    .ray_in(ray_in),
    .tri0_in(tri0_in),
    .tri1_in(tri1_in),
    .miss_valid(miss_valid),
    .miss_ray(miss_ray),
    .hit_valid(hit_valid),
    .hit_ray(hit_ray),
    .hit_isect(hit_isect)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // pulses only while items are in flight, never two for one item
  quiet_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
    (outstanding == 0) |-> (!miss_valid && !hit_valid))
    else begin
      errors++;
      $display("%0t: result pulse while no item is in flight", $time);
    end

  miss_latency: assert property (@(posedge clk) disable iff (!arst_n)
    miss_valid |-> $past(valid_in, LANE_LAT + 1))
    else begin
      errors++;
      $display("%0t: miss pulse without a valid_in 37 cycles before", $time);
    end

  hit_latency: assert property (@(posedge clk) disable iff (!arst_n)
    hit_valid |-> $past(valid_in, UNIT_LAT))
    else begin
      errors++;
      $display("%0t: hit pulse without a valid_in 38 cycles before", $time);
    end

  // a miss leads the hit slot of the same item by one cycle
  one_pulse_per_item: assert property (@(posedge clk) disable iff (!arst_n)
    hit_valid |-> !$past(miss_valid))
    else begin
      errors++;
      $display("%0t: miss and hit pulses for the same item", $time);
    end

  task automatic compare(input string name, input logic [231:0] exp_v,
                         input logic [231:0] act_v);
    assert (exp_v === act_v) else begin
      errors++;
      $display("ERROR at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_hit();
    exp_t e;
    if (exp_q.size() == 0) begin
      errors++;
      $display("%0t: hit pulse with nothing expected", $time);
      return;
    end
    e = exp_q.pop_front();
    outstanding--;
    // registered 38 edges after issue, seen at the next edge
    assert (cyc == e.issue + UNIT_LAT + 1) else begin
      errors++;
      $display("%0t: hit for ray %0d off its 38-cycle slot", $time, e.ray.ray_id);
    end
    assert (e.is_hit) else begin
      errors++;
      $display("%0t: hit pulse for ray %0d, which should miss", $time, e.ray.ray_id);
    end
    if (e.is_hit) begin
      compare("hit_ray", e.ray, hit_ray);
      compare("hit_isect.tri_id", e.isect.tri_id, hit_isect.tri_id);
      compare("hit_isect.t", e.isect.t, hit_isect.t);
      compare("hit_isect.u", e.isect.u, hit_isect.u);
      compare("hit_isect.v", e.isect.v, hit_isect.v);
      compare("hit_isect.p_int", e.isect.p_int, hit_isect.p_int);
    end
  endtask

  task automatic check_miss();
    exp_t e;
    if (exp_q.size() == 0) begin
      errors++;
      $display("%0t: miss pulse with nothing expected", $time);
      return;
    end
    e = exp_q.pop_front();
    outstanding--;
    assert (cyc == e.issue + LANE_LAT + 2) else begin
      errors++;
      $display("%0t: miss for ray %0d off its 37-cycle slot", $time, e.ray.ray_id);
    end
    assert (!e.is_hit) else begin
      errors++;
      $display("%0t: miss pulse for ray %0d, which should hit", $time, e.ray.ray_id);
    end
    compare("miss_ray", e.ray, miss_ray);
  endtask

  // the older item's hit goes first when both pulses share a cycle
  always @(posedge clk) begin
    if (arst_n) begin
      if (hit_valid) begin
        check_hit();
      end
      if (miss_valid) begin
        check_miss();
      end
    end
  end

  task automatic send(input ray_t r, input tri_t t0, input tri_t t1);
    exp_t e;
    @(posedge clk);
    valid_in <= 1'b1;
    ray_in   <= r;
    tri0_in  <= t0;
    tri1_in  <= t1;
    e = expect_item(r, t0, t1);
    e.issue = cyc;
    exp_q.push_back(e);
    outstanding++;
    items++;
  endtask

  task automatic drain();
    int n;
    n = 0;
    @(posedge clk);
    valid_in <= 1'b0;
    while (outstanding != 0 && n < DRAIN_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (outstanding != 0) begin
      errors++;
      $display("%0t: timed out with %0d results still missing", $time, outstanding);
      exp_q.delete();
      outstanding = 0;
    end
  endtask

  // identity rows with offsets on u, v and z
  function automatic tri_t ident_tri(input logic [15:0] id, input fix_t du, input fix_t dv,
                                     input fix_t dz);
    tri_t tr;
    tr.r0 = '{a: F_ONE, b: 0, c: 0, d: du};
    tr.r1 = '{a: 0, b: F_ONE, c: 0, d: dv};
    tr.r2 = '{a: 0, b: 0, c: F_ONE, d: dz};
    tr.tri_id = id;
    return tr;
  endfunction

  function automatic ray_t make_ray(input fix_t ox, input fix_t oy, input fix_t oz,
                                    input fix_t dx, input fix_t dy, input fix_t dz,
                                    input fix_t t_max, input logic [7:0] id);
    ray_t r;
    r.origin = '{x: ox, y: oy, z: oz};
    r.dir    = '{x: dx, y: dy, z: dz};
    r.t_max  = t_max;
    r.ray_id = id;
    return r;
  endfunction

  function automatic fix_t rand_range(input int lo, input int span);
    rng = lcg_next(rng);
    return fix_t'(lo + int'({8'b0, rng[31:8]} % span));
  endfunction

  // near-identity row, small off-diagonal terms and offset
  function automatic row_t rand_row(input int k);
    row_t r;
    r.a = rand_range(-8192, 16384);
    r.b = rand_range(-8192, 16384);
    r.c = rand_range(-8192, 16384);
    r.d = rand_range(-16384, 32768);
    if (k == 0) begin
      r.a = r.a + F_ONE;
    end else if (k == 1) begin
      r.b = r.b + F_ONE;
    end else begin
      r.c = r.c + F_ONE;
    end
    return r;
  endfunction

  function automatic tri_t rand_tri();
    tri_t tr;
    tr.r0 = rand_row(0);
    tr.r1 = rand_row(1);
    tr.r2 = rand_row(2);
    tr.tri_id = 16'(rand_range(0, 65536));
    return tr;
  endfunction

  task automatic send_random(input int idx);
    ray_t r;
    tri_t t0;
    tri_t t1;
    r.origin.x = rand_range(-16384, 65536);
    r.origin.y = rand_range(-16384, 65536);
    r.origin.z = rand_range(-229376, 294912);
    r.dir.x    = rand_range(-16384, 32768);
    r.dir.y    = rand_range(-16384, 32768);
    r.dir.z    = rand_range(-16384, 98304);
    r.t_max    = rand_range(0, 393216);
    r.ray_id   = idx[7:0];
    t0 = rand_tri();
    t1 = rand_tri();
    send(r, t0, t1);
  endtask

  initial begin
    ray_t base;
    tri_t tri_a;
    tri_t tri_a2;
    tri_t tri_far;
    tri_t tri_near;
    valid_in = 1'b0;
    ray_in   = '0;
    tri0_in  = '0;
    tri1_in  = '0;
    arst_n   = 1'b0;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    // quiet window after reset
    repeat (20) @(posedge clk);

    base     = make_ray(F_ONE / 4, F_ONE / 4, -2 * F_ONE, 0, 0, F_ONE, 8 * F_ONE, 8'd1);
    tri_a    = ident_tri(16'h0a00, 0, 0, 0);
    tri_a2   = ident_tri(16'h0d00, 0, 0, 0);
    tri_far  = ident_tri(16'h0b00, 5 * F_ONE, 0, 0);
    tri_near = ident_tri(16'h0c00, 0, 0, F_ONE);

    // lane 0 only, nearer lane 1, equal t
    send(base, tri_a, tri_far);
    send(base, tri_a, tri_near);
    send(base, tri_a, tri_a2);
    drain();

    // t = 2.0 against t_max below and at the limit
    send(make_ray(F_ONE / 4, F_ONE / 4, -2 * F_ONE, 0, 0, F_ONE, F_ONE, 8'd2), tri_a, tri_far);
    send(make_ray(F_ONE / 4, F_ONE / 4, -2 * F_ONE, 0, 0, F_ONE, 2 * F_ONE, 8'd3),
         tri_a, tri_far);
    drain();

    // parallel, behind the origin, outside u/v
    send(make_ray(F_ONE / 4, F_ONE / 4, -2 * F_ONE, F_ONE, 0, 0, 8 * F_ONE, 8'd4),
         tri_a, tri_far);
    send(make_ray(F_ONE / 4, F_ONE / 4, 2 * F_ONE, 0, 0, F_ONE, 8 * F_ONE, 8'd5),
         tri_a, tri_far);
    send(make_ray(32'sh0000_e666, F_ONE / 2, -2 * F_ONE, 0, 0, F_ONE, 8 * F_ONE, 8'd6),
         tri_a, tri_far);
    drain();

    for (int i = 0; i < N_RANDOM; i++) begin
      send_random(i);
    end
    drain();

    $display("%0d items issued, %0d errors", items, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+bench
hdl/rt_pkg.sv
hdl/lane_result_if.sv
hdl/delay_line.sv
hdl/prime_calc.sv
hdl/tuv_calc.sv
hdl/t_comp.sv
hdl/ray_tri_unit.sv
bench/tb_ray_tri_unit.sv
